// ==== Makefile ====
SRCS := $(shell grep -v '^+' project.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_mips_top: project.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module tb_mips_top -o Vtb_mips_top

run: obj_dir/Vtb_mips_top
	@out="$$(obj_dir/Vtb_mips_top)"; echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir

// ==== dv/mips_assert.sv ====
`default_nettype none

module mips_assert
    import mips_pkg::*;
(
    input logic      clock_i,
    input logic      rst_n_i,
    input logic      start_i,
    input reg_addr_t dbg_addr_i,
    input word_t     dbg_data_o,
    input word_cnt_t words_loaded_o,
    input logic      busy_o,
    input logic      done_o
);

    int fail_cnt = 0;

    busy_done_excl: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        !(busy_o && done_o))
        else begin
            $error("busy_o and done_o high together");
            fail_cnt++;
        end

    // an idle core always takes a start
    start_to_busy: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        start_i && !busy_o |=> busy_o)
        else begin
            $error("busy_o did not rise after start_i");
            fail_cnt++;
        end

    count_frozen: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        $past(busy_o) |-> $stable(words_loaded_o))
        else begin
            $error("words_loaded_o changed while busy_o was high");
            fail_cnt++;
        end

    r0_reads_zero: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        dbg_addr_i == '0 |-> dbg_data_o == '0)
        else begin
            $error("register 0 read nonzero");
            fail_cnt++;
        end

endmodule

bind mips_top mips_assert u_assert (
    .clock_i        (clock_i),
    .rst_n_i        (rst_n_i),
    .start_i        (start_i),
    .dbg_addr_i     (dbg_addr_i),
    .dbg_data_o     (dbg_data_o),
    .words_loaded_o (words_loaded_o),
    .busy_o         (busy_o),
    .done_o         (done_o)
);

`default_nettype wire

// ==== dv/tb_mips_top.sv ====
`default_nettype none

module tb_mips_top
    import mips_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int NUM_TESTS  = 5;
    // word count of the longest program any test sends
    localparam int MAX_WORDS  = 32;
    // bytes in, execution, register readout and some slack
    localparam int TEST_CYCLES  = MAX_WORDS * 4 + MAX_WORDS + 32 + 16;
    localparam int WATCH_CYCLES = 16 + NUM_TESTS * TEST_CYCLES * 3;

    logic      clock = 1'b0;
    logic      rst_n = 1'b0;
    logic      byte_valid = 1'b0;
    byte_t     byte_val = '0;
    logic      start = 1'b0;
    reg_addr_t dbg_addr = '0;
    word_t     dbg_data;
    word_cnt_t words_loaded;
    logic      busy;
    logic      done;

    word_t     prog[$];
    word_t     shadow[32] = '{default: '0};
    word_t     rng = 32'h7d05_4bad;
    funct_t    fns[6] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT};
    int        errors = 0;
    int        tests_run = 0;

    always #(CLK_PERIOD / 2) clock = ~clock;

    mips_top u_dut (
        .clock_i        (clock),
        .rst_n_i        (rst_n),
        .byte_valid_i   (byte_valid),
        .byte_i         (byte_val),
        .start_i        (start),
        .dbg_addr_i     (dbg_addr),
        .dbg_data_o     (dbg_data),
        .words_loaded_o (words_loaded),
        .busy_o         (busy),
        .done_o         (done)
    );

    function automatic word_t next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic word_t rtype_word(funct_t fn, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t itype_word(opcode_t op, reg_addr_t rt, reg_addr_t rs,
                                         logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // LUI for the upper half then ORI for the lower half
    function automatic void set_const(reg_addr_t r, word_t v);
        prog.push_back(itype_word(OP_LUI, r, 5'd0, v[31:16]));
        prog.push_back(itype_word(OP_ORI, r, r, v[15:0]));
    endfunction

    // executes the program in order one instruction at a time
    function automatic void run_model();
        word_t     w;
        word_t     a;
        word_t     b;
        word_t     res;
        reg_addr_t dest;
        logic      wr;
        logic      halted;
        halted = 1'b0;
        for (int i = 0; i < prog.size() && !halted; i++) begin
            w    = prog[i];
            a    = shadow[w[25:21]];
            b    = shadow[w[20:16]];
            dest = w[20:16];
            wr   = 1'b1;
            res  = '0;
            case (w[31:26])
                OP_HALT:  halted = 1'b1;
                OP_RTYPE: begin
                    dest = w[15:11];
                    case (w[5:0])
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_XOR:  res = a ^ b;
                        FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: res = a + {{16{w[15]}}, w[15:0]};
                OP_ORI:   res = a | {16'h0000, w[15:0]};
                OP_LUI:   res = {w[15:0], 16'h0000};
                default:  wr = 1'b0;
            endcase
            if (!halted && wr && dest != 5'd0) begin
                shadow[dest] = res;
            end
        end
    endfunction

    // one byte strobe per cycle with the low byte first
    task automatic load_program();
        word_t w;
        for (int i = 0; i < prog.size(); i++) begin
            w = prog[i];
            for (int k = 0; k < 4; k++) begin
                byte_valid <= 1'b1;
                byte_val   <= w[8*k +: 8];
                @(negedge clock);
            end
        end
        byte_valid <= 1'b0;
        assert (words_loaded == word_cnt_t'(prog.size())) else begin
            $display("FAIL words_loaded_o expected %h actual %h",
                     word_cnt_t'(prog.size()), words_loaded);
            errors++;
        end
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (!done && cycles < prog.size() + 16) begin
            @(negedge clock);
            cycles++;
        end
        if (!done) begin
            $display("core did not raise done_o within %0d cycles", cycles);
            errors++;
        end
    endtask

    task automatic check_regs();
        for (int r = 0; r < 32; r++) begin
            dbg_addr <= reg_addr_t'(r);
            @(posedge clock);
            assert (dbg_data === shadow[r]) else begin
                $display("FAIL dbg_data_o r%0d expected %h actual %h", r, shadow[r], dbg_data);
                errors++;
            end
            @(negedge clock);
        end
    endtask

    task automatic run_test(string name, bit poke_while_busy);
        int        errs_before;
        word_t     junk;
        errs_before = errors;
        load_program();
        start <= 1'b1;
        @(negedge clock);
        start <= 1'b0;
        if (poke_while_busy) begin
            repeat (6) begin
                junk = next_rand();
                byte_valid <= 1'b1;
                byte_val   <= junk[7:0];
                @(negedge clock);
            end
            byte_valid <= 1'b0;
            assert (busy) else begin
                $display("core finished before the bytes sent while busy were done");
                errors++;
            end
            // start cleared the count and the stray bytes must not add to it
            assert (words_loaded == '0) else begin
                $display("FAIL words_loaded_o expected %h actual %h",
                         word_cnt_t'(0), words_loaded);
                errors++;
            end
        end
        run_model();
        wait_done();
        check_regs();
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    initial begin
        word_t     v;
        reg_addr_t s;
        reg_addr_t t;
        repeat (16) @(posedge clock);
        @(negedge clock);
        rst_n <= 1'b1;
        @(negedge clock);

        // known constants
        prog.push_back(itype_word(OP_LUI, 5'd1, 5'd0, 16'h1234));
        prog.push_back(itype_word(OP_ORI, 5'd1, 5'd1, 16'h5678));
        prog.push_back(itype_word(OP_ORI, 5'd2, 5'd0, 16'hbeef));
        set_const(5'd3, 32'h8000_0001);
        prog.push_back({OP_HALT, 26'd0});
        run_test("load", 1'b0);

        // r5 negative and r6 positive so SLT sees both signs
        prog.delete();
        for (int r = 4; r < 10; r++) begin
            v = next_rand();
            if (r == 5) begin
                v[31] = 1'b1;
            end else if (r == 6) begin
                v[31] = 1'b0;
            end
            set_const(reg_addr_t'(r), v);
        end
        for (int k = 0; k < 12; k++) begin
            s = reg_addr_t'(4 + next_rand() % 6);
            t = reg_addr_t'(4 + next_rand() % 6);
            prog.push_back(rtype_word(fns[k % 6], reg_addr_t'(10 + k), s, t));
        end
        prog.push_back(rtype_word(FN_SLT, 5'd22, 5'd5, 5'd6));
        prog.push_back(rtype_word(FN_SLT, 5'd23, 5'd6, 5'd5));
        prog.push_back(itype_word(OP_ADDIU, 5'd24, 5'd6, 16'hfff0));
        prog.push_back({OP_HALT, 26'd0});
        run_test("alu", 1'b0);

        // each word depends on the one before and the halt follows a write
        prog.delete();
        prog.push_back(itype_word(OP_ADDIU, 5'd21, 5'd4, 16'd5));
        prog.push_back(rtype_word(FN_ADDU, 5'd21, 5'd21, 5'd21));
        prog.push_back(rtype_word(FN_SUBU, 5'd22, 5'd21, 5'd5));
        prog.push_back(rtype_word(FN_XOR, 5'd22, 5'd22, 5'd21));
        prog.push_back(rtype_word(FN_SLT, 5'd23, 5'd22, 5'd21));
        prog.push_back(itype_word(OP_ORI, 5'd23, 5'd23, 16'h00f0));
        prog.push_back(itype_word(OP_ADDIU, 5'd24, 5'd23, 16'hffff));
        prog.push_back({OP_HALT, 26'd0});
        run_test("forward", 1'b0);

        // r0 written and then read straight away
        prog.delete();
        prog.push_back(itype_word(OP_ORI, 5'd0, 5'd0, 16'hffff));
        prog.push_back(rtype_word(FN_ADDU, 5'd0, 5'd4, 5'd5));
        prog.push_back(itype_word(OP_LUI, 5'd0, 5'd0, 16'hdead));
        prog.push_back(rtype_word(FN_ADDU, 5'd25, 5'd0, 5'd4));
        prog.push_back(itype_word(OP_ADDIU, 5'd26, 5'd0, 16'd7));
        prog.push_back({OP_HALT, 26'd0});
        run_test("zero", 1'b0);

        // long enough to stay busy while the stray bytes go in
        prog.delete();
        repeat (8) prog.push_back(itype_word(OP_ADDIU, 5'd27, 5'd27, 16'd1));
        prog.push_back(itype_word(OP_ORI, 5'd28, 5'd0, 16'h55aa));
        prog.push_back({OP_HALT, 26'd0});
        run_test("isolation", 1'b1);

        errors += u_dut.u_assert.fail_cnt;
        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCH_CYCLES * CLK_PERIOD);
        $display("watchdog expired, the tests did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/byte_loader.sv ====
`default_nettype none

module byte_loader
    import mips_pkg::*;
(
    input  logic      clock_i,
    input  logic      rst_n_i,
    input  logic      byte_valid_i,
    input  byte_t     byte_i,
    input  logic      start_i,
    input  logic      busy_i,
    output word_cnt_t words_loaded_o,
    imem_if.loader    mem
);

    logic        load_clr;
    logic        byte_go;
    logic        word_done;
    logic [1:0]  byte_cnt_q;
    word_cnt_t   words_q;
    // holds the first three bytes of the word being built
    logic [23:0] shift_q;

    // a start only counts while the core is idle
    assign load_clr  = start_i && !busy_i;
    assign byte_go   = byte_valid_i && !busy_i && !start_i;
    assign word_done = byte_go && (byte_cnt_q == 2'd3);

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            byte_cnt_q <= '0;
            words_q    <= '0;
            mem.wr_en  <= 1'b0;
        end else begin
            mem.wr_en <= word_done;
            if (load_clr) begin
                byte_cnt_q <= '0;
                words_q    <= '0;
            end else if (byte_go) begin
                byte_cnt_q <= byte_cnt_q + 2'd1;
                if (word_done) begin
                    words_q <= words_q + 1'b1;
                end
            end
        end
    end

    // little endian, first byte ends up in bits 7:0
    always_ff @(posedge clock_i) begin
        if (byte_go) begin
            shift_q <= {byte_i, shift_q[23:8]};
        end
        if (word_done) begin
            mem.wr_data <= {byte_i, shift_q};
            mem.wr_addr <= words_q[IMEM_AW-1:0];
        end
    end

    assign words_loaded_o = words_q;

endmodule

`default_nettype wire

// ==== hdl/imem_if.sv ====
`default_nettype none

interface imem_if
    import mips_pkg::*;
();

    // write side, one word per strobe
    logic       wr_en;
    imem_addr_t wr_addr;
    word_t      wr_data;

    // read side, data valid one cycle after the address
    imem_addr_t rd_addr;
    word_t      rd_data;

    modport loader (output wr_en, wr_addr, wr_data);
    modport memory (input wr_en, wr_addr, wr_data, rd_addr, output rd_data);
    modport core   (output rd_addr, input rd_data);

endinterface

`default_nettype wire

// ==== hdl/instr_mem.sv ====
`default_nettype none

module instr_mem
    import mips_pkg::*;
(
    input  logic   clock_i,
    imem_if.memory mem
);

    // program storage, kept across runs
    word_t store [IMEM_DEPTH];

    always_ff @(posedge clock_i) begin
        if (mem.wr_en) begin
            store[mem.wr_addr] <= mem.wr_data;
        end
    end

    // registered read port
    always_ff @(posedge clock_i) begin
        mem.rd_data <= store[mem.rd_addr];
    end

endmodule

`default_nettype wire

// ==== hdl/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    // instruction memory geometry
    localparam int unsigned IMEM_AW    = 6;
    localparam int unsigned IMEM_DEPTH = 1 << IMEM_AW;

    typedef logic [31:0]        word_t;
    typedef logic [7:0]         byte_t;
    typedef logic [4:0]         reg_addr_t;
    typedef logic [IMEM_AW-1:0] imem_addr_t;
    // one extra bit so a full memory can be counted
    typedef logic [IMEM_AW:0]   word_cnt_t;
    typedef logic [5:0]         opcode_t;
    typedef logic [5:0]         funct_t;

    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_LUI   = 6'h0f;
    localparam opcode_t OP_HALT  = 6'h3f;

    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_SLT  = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADDU,
        ALU_SUBU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DRAIN,
        ST_DONE
    } core_state_t;

endpackage

`default_nettype wire

// ==== hdl/mips_top.sv ====
`default_nettype none

module mips_top
    import mips_pkg::*;
(
    input  logic      clock_i,
    input  logic      rst_n_i,
    input  logic      byte_valid_i,
    input  byte_t     byte_i,
    input  logic      start_i,
    input  reg_addr_t dbg_addr_i,
    output word_t     dbg_data_o,
    output word_cnt_t words_loaded_o,
    output logic      busy_o,
    output logic      done_o
);

    imem_if imem_bus ();

    // loader is locked out while the core runs
    byte_loader u_loader (
        .clock_i        (clock_i),
        .rst_n_i        (rst_n_i),
        .byte_valid_i   (byte_valid_i),
        .byte_i         (byte_i),
        .start_i        (start_i),
        .busy_i         (busy_o),
        .words_loaded_o (words_loaded_o),
        .mem            (imem_bus.loader)
    );

    instr_mem u_imem (
        .clock_i (clock_i),
        .mem     (imem_bus.memory)
    );

    pipe_core u_core (
        .clock_i    (clock_i),
        .rst_n_i    (rst_n_i),
        .start_i    (start_i),
        .mem        (imem_bus.core),
        .dbg_addr_i (dbg_addr_i),
        .dbg_data_o (dbg_data_o),
        .busy_o     (busy_o),
        .done_o     (done_o)
    );

endmodule

`default_nettype wire

// ==== hdl/pipe_core.sv ====
`default_nettype none

module pipe_core
    import mips_pkg::*;
(
    input  logic      clock_i,
    input  logic      rst_n_i,
    input  logic      start_i,
    imem_if.core      mem,
    input  reg_addr_t dbg_addr_i,
    output word_t     dbg_data_o,
    output logic      busy_o,
    output logic      done_o
);

    core_state_t state_q;
    word_cnt_t   pc_q;
    logic        fetch_valid_q;
    logic        pc_end;
    logic        halt_now;
    logic        fetch_go;

    word_t       regs [32];

    opcode_t     ex_op;
    funct_t      ex_funct;
    reg_addr_t   ex_rs;
    reg_addr_t   ex_rt;
    reg_addr_t   ex_rd;
    logic [15:0] ex_imm;
    word_t       ex_imm_ext;
    logic        ex_use_imm;
    logic        ex_wr;
    logic        ex_we;
    logic        ex_halt;
    reg_addr_t   ex_dest;
    alu_op_t     ex_alu_op;
    logic        fwd_a;
    logic        fwd_b;
    word_t       ex_a;
    word_t       ex_rt_val;
    word_t       ex_b;
    word_t       ex_result;

    logic        wb_we_q;
    reg_addr_t   wb_dest_q;
    word_t       wb_data_q;

    // run control and fetch
    assign pc_end   = (pc_q == word_cnt_t'(IMEM_DEPTH));
    assign halt_now = ex_halt || (pc_end && !fetch_valid_q);
    assign fetch_go = (state_q == ST_RUN) && !halt_now && !pc_end;

    assign mem.rd_addr = pc_q[IMEM_AW-1:0];

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q       <= ST_IDLE;
            pc_q          <= '0;
            fetch_valid_q <= 1'b0;
        end else begin
            // word behind a halt is dropped here
            fetch_valid_q <= fetch_go;
            case (state_q)
                ST_IDLE, ST_DONE: begin
                    if (start_i) begin
                        state_q <= ST_RUN;
                        pc_q    <= '0;
                    end
                end
                ST_RUN: begin
                    if (halt_now) begin
                        state_q <= ST_DRAIN;
                    end else if (fetch_go) begin
                        pc_q <= pc_q + 1'b1;
                    end
                end
                ST_DRAIN: state_q <= ST_DONE;
                default:  state_q <= ST_IDLE;
            endcase
        end
    end

    assign busy_o = (state_q == ST_RUN) || (state_q == ST_DRAIN);
    assign done_o = (state_q == ST_DONE);

    // field decode
    assign ex_op    = mem.rd_data[31:26];
    assign ex_rs    = mem.rd_data[25:21];
    assign ex_rt    = mem.rd_data[20:16];
    assign ex_rd    = mem.rd_data[15:11];
    assign ex_imm   = mem.rd_data[15:0];
    assign ex_funct = mem.rd_data[5:0];

    always_comb begin
        ex_alu_op  = ALU_ADDU;
        ex_use_imm = 1'b0;
        ex_wr      = 1'b0;
        ex_dest    = ex_rt;
        ex_imm_ext = {{16{ex_imm[15]}}, ex_imm};
        case (ex_op)
            OP_RTYPE: begin
                ex_dest = ex_rd;
                ex_wr   = 1'b1;
                case (ex_funct)
                    FN_ADDU: ex_alu_op = ALU_ADDU;
                    FN_SUBU: ex_alu_op = ALU_SUBU;
                    FN_AND:  ex_alu_op = ALU_AND;
                    FN_OR:   ex_alu_op = ALU_OR;
                    FN_XOR:  ex_alu_op = ALU_XOR;
                    FN_SLT:  ex_alu_op = ALU_SLT;
                    // unknown function acts as a nop
                    default: ex_wr = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                ex_use_imm = 1'b1;
                ex_wr      = 1'b1;
            end
            OP_ORI: begin
                ex_alu_op  = ALU_OR;
                ex_use_imm = 1'b1;
                ex_wr      = 1'b1;
                ex_imm_ext = {16'h0000, ex_imm};
            end
            OP_LUI: begin
                ex_alu_op  = ALU_LUI;
                ex_use_imm = 1'b1;
                ex_wr      = 1'b1;
                ex_imm_ext = {16'h0000, ex_imm};
            end
            default: ex_wr = 1'b0;
        endcase
    end

    assign ex_halt = fetch_valid_q && (ex_op == OP_HALT);
    assign ex_we   = fetch_valid_q && ex_wr && (ex_dest != '0);

    // operand read, forwarded from writeback
    assign fwd_a = wb_we_q && (wb_dest_q == ex_rs) && (ex_rs != '0);
    assign fwd_b = wb_we_q && (wb_dest_q == ex_rt) && (ex_rt != '0);

    assign ex_a      = (ex_rs == '0) ? '0 : (fwd_a ? wb_data_q : regs[ex_rs]);
    assign ex_rt_val = (ex_rt == '0) ? '0 : (fwd_b ? wb_data_q : regs[ex_rt]);
    assign ex_b      = ex_use_imm ? ex_imm_ext : ex_rt_val;

    always_comb begin
        case (ex_alu_op)
            ALU_ADDU: ex_result = ex_a + ex_b;
            ALU_SUBU: ex_result = ex_a - ex_b;
            ALU_AND:  ex_result = ex_a & ex_b;
            ALU_OR:   ex_result = ex_a | ex_b;
            ALU_XOR:  ex_result = ex_a ^ ex_b;
            ALU_SLT:  ex_result = {31'd0, $signed(ex_a) < $signed(ex_b)};
            ALU_LUI:  ex_result = {ex_b[15:0], 16'h0000};
            default:  ex_result = ex_a + ex_b;
        endcase
    end

    // writeback stage
    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_we_q <= 1'b0;
        end else begin
            wb_we_q <= ex_we;
        end
    end

    always_ff @(posedge clock_i) begin
        wb_dest_q <= ex_dest;
        wb_data_q <= ex_result;
    end

    // register file, r0 never written
    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we_q) begin
            regs[wb_dest_q] <= wb_data_q;
        end
    end

    assign dbg_data_o = (dbg_addr_i == '0) ? '0 : regs[dbg_addr_i];

endmodule

`default_nettype wire

// ==== project.f ====
hdl/mips_pkg.sv
hdl/imem_if.sv
hdl/byte_loader.sv
hdl/instr_mem.sv
hdl/pipe_core.sv
hdl/mips_top.sv
dv/mips_assert.sv
dv/tb_mips_top.sv
